// File: Makefile
VERILATOR ?= verilator
TOP       ?= rename_unit_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/rename_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rename_unit_tb import rename_pkg::*; ();

  localparam int RENAME_WIDTH = 2;
  // Deep enough that the free list can run dry before the queue fills
  localparam int RETIRE_DEPTH = 20;
  localparam int PERIOD       = 8;
  localparam int RESET_CYCLES = 3;

  // Test lengths in cycles including the retire queue drains
  localparam int MAP_LEN      = 16;
  localparam int ALLOC_LEN    = 24;
  localparam int FWD_LEN      = 60;
  localparam int FREE_LEN     = 24;
  localparam int RECYCLE_LEN  = 200;
  localparam int RETIRE_LEN   = RETIRE_DEPTH + 5;
  localparam int TOTAL_CYCLES = RESET_CYCLES + MAP_LEN + ALLOC_LEN + FWD_LEN + FREE_LEN
                                + RECYCLE_LEN + RETIRE_LEN + 2 * RETIRE_DEPTH;
  localparam int TIMEOUT_NS   = (TOTAL_CYCLES + 50) * PERIOD;

  logic                         clk;
  logic                         rst;
  logic                         rename_valid;
  logic                         rename_ready;
  logic [RENAME_WIDTH-1:0]      dst_valid;
  arch_reg_t [RENAME_WIDTH-1:0] dst_arch;
  arch_reg_t [RENAME_WIDTH-1:0] src1_arch;
  arch_reg_t [RENAME_WIDTH-1:0] src2_arch;
  phys_reg_t [RENAME_WIDTH-1:0] src1_phys;
  phys_reg_t [RENAME_WIDTH-1:0] src2_phys;
  phys_reg_t [RENAME_WIDTH-1:0] dst_phys;
  phys_reg_t [RENAME_WIDTH-1:0] old_phys;
  logic                         commit;

  // Reference model state
  int                      model_map [NUM_ARCH_REGS];
  int                      free_q [$];
  logic [RENAME_WIDTH-1:0] ret_mask_q [$];
  int                      ret_regs_q [$];

  string current_test;
  int    err_count;
  int    test_err_start;
  int    tests_run;
  int    tests_failed;
  int    ready_low_cycles;

  tb_clock #(
    .PERIOD       (PERIOD),
    .RESET_CYCLES (RESET_CYCLES)
  ) tb_clock_i (
    .clk (clk),
    .rst (rst)
  );

  rename_unit #(
    .RENAME_WIDTH (RENAME_WIDTH),
    .RETIRE_DEPTH (RETIRE_DEPTH)
  ) rename_unit_i (
    .clk          (clk),
    .rst          (rst),
    .rename_valid (rename_valid),
    .rename_ready (rename_ready),
    .dst_valid    (dst_valid),
    .dst_arch     (dst_arch),
    .src1_arch    (src1_arch),
    .src2_arch    (src2_arch),
    .src1_phys    (src1_phys),
    .src2_phys    (src2_phys),
    .dst_phys     (dst_phys),
    .old_phys     (old_phys),
    .commit       (commit)
  );

  function automatic logic chance(input int pct);
    return int'($urandom % 100) < pct;
  endfunction

  task automatic check_value(input string what, input int expected, input int actual);
    if (expected != actual) begin
      $display("FAILED %s: %s expected %0d, actual %0d", current_test, what, expected,
               actual);
      err_count++;
    end
  endtask

  // Commit is only drawn while the model holds a group
  task automatic drive_random(input int valid_pct, input int dst_pct, input int commit_pct,
                              input int arch_range);
    rename_valid = chance(valid_pct);
    for (int j = 0; j < RENAME_WIDTH; j++) begin
      dst_valid[j] = chance(dst_pct);
      dst_arch[j]  = arch_reg_t'($urandom % arch_range);
      src1_arch[j] = arch_reg_t'($urandom % arch_range);
      src2_arch[j] = arch_reg_t'($urandom % arch_range);
    end
    commit = chance(commit_pct) && (ret_mask_q.size() > 0);
  endtask

  // Compare one cycle against the model and step the model over the rising edge
  task automatic check_cycle();
    int                      tmp_map [NUM_ARCH_REGS];
    int                      exp_src;
    int                      exp_dst;
    int                      exp_old [RENAME_WIDTH];
    int                      taken;
    logic                    exp_ready;
    logic [RENAME_WIDTH-1:0] done_mask;
    int                      freed;
    #1;
    tmp_map   = model_map;
    taken     = 0;
    exp_ready = (free_q.size() >= RENAME_WIDTH) && (ret_mask_q.size() < RETIRE_DEPTH);
    check_value("rename_ready", int'(exp_ready), int'(rename_ready));
    if (rename_ready !== 1'b1) begin
      ready_low_cycles++;
    end
    // Each lane sees the writes of the lanes before it
    for (int j = 0; j < RENAME_WIDTH; j++) begin
      exp_old[j] = 0;
      exp_src = tmp_map[src1_arch[j]];
      if (exp_src >= 0) begin
        check_value($sformatf("src1_phys[%0d]", j), exp_src, int'(src1_phys[j]));
      end
      exp_src = tmp_map[src2_arch[j]];
      if (exp_src >= 0) begin
        check_value($sformatf("src2_phys[%0d]", j), exp_src, int'(src2_phys[j]));
      end
      if (dst_valid[j]) begin
        exp_old[j] = tmp_map[dst_arch[j]];
        // Past the end of the free list the register is unknown
        exp_dst = (taken < free_q.size()) ? free_q[taken] : -1;
        taken++;
        tmp_map[dst_arch[j]] = exp_dst;
        if (exp_dst >= 0) begin
          check_value($sformatf("dst_phys[%0d]", j), exp_dst, int'(dst_phys[j]));
        end
        if (exp_old[j] >= 0) begin
          check_value($sformatf("old_phys[%0d]", j), exp_old[j], int'(old_phys[j]));
        end
      end else begin
        check_value($sformatf("dst_phys[%0d]", j), 0, int'(dst_phys[j]));
      end
    end
    if (rename_valid && exp_ready && rename_ready === exp_ready) begin
      model_map = tmp_map;
      for (int j = 0; j < taken; j++) begin
        void'(free_q.pop_front());
      end
      ret_mask_q.push_back(dst_valid);
      for (int j = 0; j < RENAME_WIDTH; j++) begin
        ret_regs_q.push_back(exp_old[j]);
      end
    end
    if (commit && ret_mask_q.size() > 0) begin
      done_mask = ret_mask_q.pop_front();
      for (int j = 0; j < RENAME_WIDTH; j++) begin
        freed = ret_regs_q.pop_front();
        if (done_mask[j]) begin
          free_q.push_back(freed);
        end
      end
    end
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic start_test(input string name);
    current_test     = name;
    test_err_start   = err_count;
    ready_low_cycles = 0;
    tests_run++;
  endtask

  task automatic end_test();
    if (err_count == test_err_start) begin
      $display("test %-18s passed", current_test);
    end else begin
      $display("test %-18s failed with %0d errors", current_test, err_count - test_err_start);
      tests_failed++;
    end
  endtask

  task automatic run_random(input int cycles, input int valid_pct, input int dst_pct,
                            input int commit_pct, input int arch_range);
    repeat (cycles) begin
      drive_random(valid_pct, dst_pct, commit_pct, arch_range);
      check_cycle();
    end
  endtask

  // Commit every group in flight so all displaced registers are free again
  task automatic drain_queue();
    while (ret_mask_q.size() > 0) begin
      drive_random(0, 0, 100, NUM_ARCH_REGS);
      check_cycle();
    end
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
    $display("Something failed");
    $finish;
  end

  initial begin
    void'($urandom(32'hca5c));
    rename_valid = 1'b0;
    dst_valid    = '0;
    dst_arch     = '0;
    src1_arch    = '0;
    src2_arch    = '0;
    commit       = 1'b0;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int i = 0; i < NUM_ARCH_REGS; i++) begin
      model_map[i] = i;
    end
    for (int i = NUM_ARCH_REGS; i < NUM_PHYS_REGS; i++) begin
      free_q.push_back(i);
    end
    wait (rst === 1'b0);
    @(negedge clk);

    start_test("reset_mapping");
    for (int c = 0; c < MAP_LEN; c++) begin
      drive_random(0, 0, 0, NUM_ARCH_REGS);
      for (int j = 0; j < RENAME_WIDTH; j++) begin
        src1_arch[j] = arch_reg_t'(RENAME_WIDTH * c + j);
        src2_arch[j] = arch_reg_t'(NUM_ARCH_REGS - 1 - (RENAME_WIDTH * c + j));
      end
      check_cycle();
    end
    end_test();

    start_test("allocation_order");
    run_random(ALLOC_LEN, 70, 80, 0, NUM_ARCH_REGS);
    end_test();

    // Four registers only so lanes collide often
    start_test("forwarding");
    run_random(FWD_LEN, 80, 80, 60, 4);
    end_test();

    start_test("free_backpressure");
    drain_queue();
    ready_low_cycles = 0;
    run_random(FREE_LEN, 100, 100, 0, NUM_ARCH_REGS);
    if (ready_low_cycles == 0) begin
      $display("rename_ready never dropped while the free list ran dry");
      err_count++;
    end
    end_test();

    start_test("commit_recycling");
    run_random(RECYCLE_LEN, 70, 70, 50, NUM_ARCH_REGS);
    end_test();

    // Groups without destinations fill the queue and leave the free list untouched
    start_test("retire_backpressure");
    drain_queue();
    ready_low_cycles = 0;
    run_random(RETIRE_DEPTH + 4, 100, 0, 0, NUM_ARCH_REGS);
    if (ready_low_cycles == 0) begin
      $display("rename_ready stayed high with the retire queue full");
      err_count++;
    end
    run_random(1, 0, 0, 100, NUM_ARCH_REGS);
    if (rename_ready !== 1'b1) begin
      $display("rename_ready did not rise in the cycle after a commit");
      err_count++;
    end
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Release reset just after the last reset edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

// File: project.f
source/rename_pkg.sv
source/free_list.sv
source/reg_alias_table.sv
source/retire_queue.sv
source/rename_unit.sv
dv/tb_clock.sv
dv/rename_unit_tb.sv

// File: source/free_list.sv
`timescale 1ns/1ns
`default_nettype none

module free_list import rename_pkg::*; #(
  parameter int RENAME_WIDTH = 2
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          acquire,
  input  logic [RENAME_WIDTH-1:0]       acquire_lanes,
  output phys_reg_t [RENAME_WIDTH-1:0]  lane_regs,
  output logic                          enough,
  input  logic [RENAME_WIDTH-1:0]       free_valid,
  input  phys_reg_t [RENAME_WIDTH-1:0]  free_regs
);

  // Circular buffer, pointers wrap naturally at NUM_PHYS_REGS
  phys_reg_t   fifo_q [NUM_PHYS_REGS];
  phys_reg_t   head_q;
  phys_reg_t   tail_q;
  free_count_t count_q;

  // Per-lane offsets from head and tail
  phys_reg_t   acq_off [RENAME_WIDTH];
  phys_reg_t   rel_off [RENAME_WIDTH];
  free_count_t acq_cnt;
  free_count_t rel_cnt;
  free_count_t acq_taken;

  always_comb begin
    acq_cnt = '0;
    rel_cnt = '0;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      acq_off[i] = phys_reg_t'(acq_cnt);
      rel_off[i] = phys_reg_t'(rel_cnt);
      if (acquire_lanes[i]) begin
        acq_cnt = acq_cnt + free_count_t'(1);
      end
      if (free_valid[i]) begin
        rel_cnt = rel_cnt + free_count_t'(1);
      end
    end
  end

  // Requesting lanes take consecutive entries starting at head
  always_comb begin
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      lane_regs[i] = fifo_q[head_q + acq_off[i]];
    end
  end

  assign acq_taken = acquire ? acq_cnt : free_count_t'(0);

  // Only registers already in the list count, freed ones show up next cycle
  assign enough = (count_q >= free_count_t'(RENAME_WIDTH));

  always_ff @(posedge clk) begin
    if (rst) begin
      // Registers 32..63 sit in slots 0..31, the rest is don't care
      for (int i = 0; i < NUM_PHYS_REGS; i++) begin
        fifo_q[i] <= phys_reg_t'(i + NUM_ARCH_REGS);
      end
      head_q  <= '0;
      tail_q  <= phys_reg_t'(NUM_PHYS_REGS - NUM_ARCH_REGS);
      count_q <= free_count_t'(NUM_PHYS_REGS - NUM_ARCH_REGS);
    end else begin
      // Append freed registers in lane order
      for (int i = 0; i < RENAME_WIDTH; i++) begin
        if (free_valid[i]) begin
          fifo_q[tail_q + rel_off[i]] <= free_regs[i];
        end
      end
      tail_q  <= tail_q + phys_reg_t'(rel_cnt);
      head_q  <= head_q + phys_reg_t'(acq_taken);
      count_q <= count_q + rel_cnt - acq_taken;
    end
  end

  // More registers than exist means something got freed twice
  a_count_bound : assert property (
    @(posedge clk) disable iff (rst)
    count_q <= free_count_t'(NUM_PHYS_REGS)
  );

  // The top must hold off the fire until enough registers are free
  a_acquire_enough : assert property (
    @(posedge clk) disable iff (rst)
    acquire |-> enough
  );

endmodule

`default_nettype wire

// File: source/reg_alias_table.sv
`timescale 1ns/1ns
`default_nettype none

module reg_alias_table import rename_pkg::*; #(
  parameter int RENAME_WIDTH = 2
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          write,
  input  logic [RENAME_WIDTH-1:0]       dst_valid,
  input  arch_reg_t [RENAME_WIDTH-1:0]  dst_arch,
  input  arch_reg_t [RENAME_WIDTH-1:0]  src1_arch,
  input  arch_reg_t [RENAME_WIDTH-1:0]  src2_arch,
  input  phys_reg_t [RENAME_WIDTH-1:0]  new_phys,
  output phys_reg_t [RENAME_WIDTH-1:0]  src1_phys,
  output phys_reg_t [RENAME_WIDTH-1:0]  src2_phys,
  output phys_reg_t [RENAME_WIDTH-1:0]  old_phys
);

  phys_reg_t map_q [NUM_ARCH_REGS];

  // Mapping of arch as seen by the given lane: the table value,
  // overridden by the youngest earlier lane in the group writing arch
  function automatic phys_reg_t lookup(input arch_reg_t arch, input int lane);
    phys_reg_t result;
    result = map_q[arch];
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      if (i < lane && dst_valid[i] && dst_arch[i] == arch) begin
        result = new_phys[i];
      end
    end
    return result;
  endfunction

  always_comb begin
    for (int j = 0; j < RENAME_WIDTH; j++) begin
      src1_phys[j] = lookup(src1_arch[j], j);
      src2_phys[j] = lookup(src2_arch[j], j);
      // A forwarded value here means the earlier lane's register is displaced
      old_phys[j]  = lookup(dst_arch[j], j);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      // Identity mapping
      for (int i = 0; i < NUM_ARCH_REGS; i++) begin
        map_q[i] <= phys_reg_t'(i);
      end
    end else if (write) begin
      // Later lanes come last so they win on a shared destination
      for (int i = 0; i < RENAME_WIDTH; i++) begin
        if (dst_valid[i]) begin
          map_q[dst_arch[i]] <= new_phys[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: source/rename_pkg.sv
`default_nettype none

package rename_pkg;

  // Register file sizes
  localparam int NUM_ARCH_REGS = 32;
  localparam int NUM_PHYS_REGS = 64;

  // Register indices
  typedef logic [$clog2(NUM_ARCH_REGS)-1:0] arch_reg_t;
  typedef logic [$clog2(NUM_PHYS_REGS)-1:0] phys_reg_t;

  // One extra bit so a completely full free list can be counted
  typedef logic [$clog2(NUM_PHYS_REGS):0] free_count_t;

endpackage

`default_nettype wire

// File: source/rename_unit.sv
`timescale 1ns/1ns
`default_nettype none

module rename_unit import rename_pkg::*; #(
  parameter int RENAME_WIDTH = 2,
  parameter int RETIRE_DEPTH = 4
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          rename_valid,
  output logic                          rename_ready,
  input  logic [RENAME_WIDTH-1:0]       dst_valid,
  input  arch_reg_t [RENAME_WIDTH-1:0]  dst_arch,
  input  arch_reg_t [RENAME_WIDTH-1:0]  src1_arch,
  input  arch_reg_t [RENAME_WIDTH-1:0]  src2_arch,
  output phys_reg_t [RENAME_WIDTH-1:0]  src1_phys,
  output phys_reg_t [RENAME_WIDTH-1:0]  src2_phys,
  output phys_reg_t [RENAME_WIDTH-1:0]  dst_phys,
  output phys_reg_t [RENAME_WIDTH-1:0]  old_phys,
  input  logic                          commit
);

  logic                         enough;
  logic                         full;
  logic                         fire;
  phys_reg_t [RENAME_WIDTH-1:0] lane_regs;
  logic [RENAME_WIDTH-1:0]      free_valid;
  phys_reg_t [RENAME_WIDTH-1:0] free_regs;

  // Stall on too few free registers or no room to track the group
  assign rename_ready = enough && !full;
  assign fire         = rename_valid && rename_ready;

  always_comb begin
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      dst_phys[i] = dst_valid[i] ? lane_regs[i] : '0;
    end
  end

  free_list #(
    .RENAME_WIDTH (RENAME_WIDTH)
  ) free_list_i (
    .clk           (clk),
    .rst           (rst),
    .acquire       (fire),
    .acquire_lanes (dst_valid),
    .lane_regs     (lane_regs),
    .enough        (enough),
    .free_valid    (free_valid),
    .free_regs     (free_regs)
  );

  reg_alias_table #(
    .RENAME_WIDTH (RENAME_WIDTH)
  ) reg_alias_table_i (
    .clk       (clk),
    .rst       (rst),
    .write     (fire),
    .dst_valid (dst_valid),
    .dst_arch  (dst_arch),
    .src1_arch (src1_arch),
    .src2_arch (src2_arch),
    .new_phys  (lane_regs),
    .src1_phys (src1_phys),
    .src2_phys (src2_phys),
    .old_phys  (old_phys)
  );

  // Displaced registers wait here until their group commits
  retire_queue #(
    .RENAME_WIDTH (RENAME_WIDTH),
    .RETIRE_DEPTH (RETIRE_DEPTH)
  ) retire_queue_i (
    .clk        (clk),
    .rst        (rst),
    .push       (fire),
    .push_mask  (dst_valid),
    .push_regs  (old_phys),
    .commit     (commit),
    .full       (full),
    .free_valid (free_valid),
    .free_regs  (free_regs)
  );

endmodule

`default_nettype wire

// File: source/retire_queue.sv
`timescale 1ns/1ns
`default_nettype none

module retire_queue import rename_pkg::*; #(
  parameter int RENAME_WIDTH = 2,
  parameter int RETIRE_DEPTH = 4
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          push,
  input  logic [RENAME_WIDTH-1:0]       push_mask,
  input  phys_reg_t [RENAME_WIDTH-1:0]  push_regs,
  input  logic                          commit,
  output logic                          full,
  output logic [RENAME_WIDTH-1:0]       free_valid,
  output phys_reg_t [RENAME_WIDTH-1:0]  free_regs
);

  localparam int PTR_W = (RETIRE_DEPTH > 1) ? $clog2(RETIRE_DEPTH) : 1;
  localparam int CNT_W = $clog2(RETIRE_DEPTH + 1);

  // Group payload
  logic [RENAME_WIDTH-1:0]      mask_q [RETIRE_DEPTH];
  phys_reg_t [RENAME_WIDTH-1:0] regs_q [RETIRE_DEPTH];

  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             empty;
  logic             pop;

  assign empty = (count_q == '0);
  assign full  = (count_q == CNT_W'(RETIRE_DEPTH));
  assign pop   = commit && !empty;

  // Oldest group goes back to the free list during the commit cycle
  assign free_valid = pop ? mask_q[rd_ptr_q] : '0;
  assign free_regs  = regs_q[rd_ptr_q];

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(RETIRE_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  always_ff @(posedge clk) begin
    if (push) begin
      mask_q[wr_ptr_q] <= push_mask;
      regs_q[wr_ptr_q] <= push_regs;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  a_no_push_full : assert property (
    @(posedge clk) disable iff (rst)
    push |-> !full
  );

  // Commit must only follow a renamed group still in flight
  a_no_commit_empty : assert property (
    @(posedge clk) disable iff (rst)
    commit |-> !empty
  );

endmodule

`default_nettype wire
